//--- source/pattern_defs.svh
/*
 * pattern source constants
 * video timing, square geometry, register map, reset values and i2s framing
 */
`ifndef PATTERN_DEFS_SVH
`define PATTERN_DEFS_SVH

// horizontal timing, in clocks
`define H_TOTAL       400
`define H_ACTIVE      320
`define H_BPORCH      10
`define HS_X          3

// vertical timing, in lines
`define V_TOTAL       512
`define V_ACTIVE      240
`define V_BPORCH      10

// moving square
`define SQUARE_SIZE   10
`define SQUARE_X0     135
`define SQUARE_Y0     95

// colour reset values, 8:8:8 rgb
`define BG_RESET      24'h3C3C3C
`define SQ_RESET      24'h000000

// apb register offsets
`define REG_CTRL      8'h00
`define REG_BG        8'h04
`define REG_SQ_POS    8'h08
`define REG_SQ_COLOR  8'h0C
`define REG_AUDIO     8'h10
`define REG_FRAME     8'h14

// i2s framing
`define MCLK_PER_BCLK 4
`define SLOT_BITS     32
`define SAMPLE_BITS   16

`endif

//--- source/pattern_pkg.sv
/*
 * pattern source types
 * colours, square position, stereo sample, raster and video buses
 */
`default_nettype none

package pattern_pkg;

    // 8:8:8 colour
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // square top-left corner in visible coordinates
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } square_pos_t;

    // left channel in the upper half
    typedef struct packed {
        logic [15:0] left;
        logic [15:0] right;
    } stereo_sample_t;

    // apb data word, meaning depends on the register offset
    typedef union packed {
        struct packed {
            logic [7:0] pad;
            rgb_t       rgb;
        } color;
        struct packed {
            logic [5:0] pad_hi;
            logic [9:0] x;
            logic [5:0] pad_lo;
            logic [9:0] y;
        } pos;
        stereo_sample_t sample;
    } reg_word_u;

    // scene settings, registers to renderer
    typedef struct packed {
        rgb_t        bg_color;
        rgb_t        sq_color;
        square_pos_t sq_pos;
    } scene_cfg_t;

    // raster position, timing to renderer
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       line_start;
        logic       frame_start;
    } raster_t;

    // registered video stream
    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic vs;
        logic hs;
    } video_out_t;

endpackage

`default_nettype wire

//--- source/apb_regs.sv
/*
 * apb register block
 * control, colours, square position, audio sample and frame counter
 * steps the square once per frame when motion is on
 */
`timescale 1ns/1ps
`default_nettype none
`include "pattern_defs.svh"

module apb_regs (
    input  wire                         audgen_mclk,
    input  wire                         reset_n,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire  [7:0]                  paddr,
    input  wire  [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  pattern_pkg::raster_t        raster,
    output pattern_pkg::scene_cfg_t     scene,
    output pattern_pkg::stereo_sample_t sample
);

    logic                        ctrl_motion;
    pattern_pkg::rgb_t           bg_color;
    pattern_pkg::rgb_t           sq_color;
    pattern_pkg::square_pos_t    sq_pos;
    pattern_pkg::stereo_sample_t audio;
    logic [15:0]                 frame_cnt;

    pattern_pkg::reg_word_u      wr_word;
    pattern_pkg::reg_word_u      rd_word;
    logic                        access;
    logic                        mapped;
    logic                        wr_ok;

    //////////////////////////////
    // transfer decode
    //////////////////////////////

    // zero wait states
    assign pready  = 1'b1;
    assign access  = psel & penable;
    assign wr_word = pwdata;

    always_comb begin
        case (paddr)
            `REG_CTRL, `REG_BG, `REG_SQ_POS, `REG_SQ_COLOR, `REG_AUDIO, `REG_FRAME:
                mapped = 1'b1;
            default:
                mapped = 1'b0;
        endcase
    end

    // frame counter is read-only
    assign pslverr = access & (~mapped | (pwrite & (paddr == `REG_FRAME)));
    assign wr_ok   = access & pwrite & ~pslverr;

    //////////////////////////////
    // registers
    //////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_motion <= 1'b0;
            bg_color    <= `BG_RESET;
            sq_color    <= `SQ_RESET;
            sq_pos.x    <= 10'(`SQUARE_X0);
            sq_pos.y    <= 10'(`SQUARE_Y0);
            audio       <= '0;
            frame_cnt   <= '0;
        end else begin
            if (wr_ok && paddr == `REG_CTRL)
                ctrl_motion <= pwdata[0];
            if (wr_ok && paddr == `REG_BG)
                bg_color <= wr_word.color.rgb;
            if (wr_ok && paddr == `REG_SQ_COLOR)
                sq_color <= wr_word.color.rgb;
            if (wr_ok && paddr == `REG_AUDIO)
                audio <= wr_word.sample;
            // software write beats the per-frame step
            if (wr_ok && paddr == `REG_SQ_POS) begin
                sq_pos.x <= wr_word.pos.x;
                sq_pos.y <= wr_word.pos.y;
            end else if (raster.frame_start && ctrl_motion) begin
                sq_pos.x <= sq_pos.x + 10'd1;
                sq_pos.y <= sq_pos.y + 10'd1;
            end
            if (raster.frame_start)
                frame_cnt <= frame_cnt + 16'd1;
        end
    end

    // read mux, combinational during access
    always_comb begin
        rd_word = '0;
        case (paddr)
            `REG_CTRL:     rd_word[0] = ctrl_motion;
            `REG_BG:       rd_word.color.rgb = bg_color;
            `REG_SQ_COLOR: rd_word.color.rgb = sq_color;
            `REG_AUDIO:    rd_word.sample = audio;
            `REG_FRAME:    rd_word[15:0] = frame_cnt;
            `REG_SQ_POS: begin
                rd_word.pos.x = sq_pos.x;
                rd_word.pos.y = sq_pos.y;
            end
            default:       rd_word = '0;
        endcase
    end

    assign prdata         = rd_word;
    assign scene.bg_color = bg_color;
    assign scene.sq_color = sq_color;
    assign scene.sq_pos   = sq_pos;
    assign sample         = audio;

endmodule

`default_nettype wire

//--- source/video_timing.sv
/*
 * video timing
 * 400 x 512 raster counters with line and frame start flags
 */
`timescale 1ns/1ps
`default_nettype none
`include "pattern_defs.svh"

module video_timing (
    input  wire                  audgen_mclk,
    input  wire                  reset_n,
    output pattern_pkg::raster_t raster
);

    logic [9:0] x_count;
    logic [9:0] y_count;
    logic       x_last;
    logic       y_last;

    //////////////////////////////
    // raster counters
    //////////////////////////////

    // end of line and end of frame
    assign x_last = (x_count == 10'(`H_TOTAL - 1));
    assign y_last = (y_count == 10'(`V_TOTAL - 1));

    // horizontal, one step per clock
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
        end else if (x_last) begin
            x_count <= '0;
        end else begin
            x_count <= x_count + 10'd1;
        end
    end

    // vertical, one step per line
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            y_count <= '0;
        end else if (x_last) begin
            if (y_last)
                y_count <= '0;
            else
                y_count <= y_count + 10'd1;
        end
    end

    //////////////////////////////
    // raster out
    //////////////////////////////

    assign raster.x = x_count;
    assign raster.y = y_count;

    // first clock of each line
    assign raster.line_start = (x_count == 10'd0);

    // raster (0,0) opens a frame
    assign raster.frame_start = (x_count == 10'd0) && (y_count == 10'd0);

endmodule

`default_nettype wire

//--- source/pattern_render.sv
/*
 * pattern renderer
 * registered sync, data enable and colour
 * solid background with one square, one clock behind the raster
 */
`timescale 1ns/1ps
`default_nettype none
`include "pattern_defs.svh"

module pattern_render (
    input  wire                     audgen_mclk,
    input  wire                     reset_n,
    input  pattern_pkg::raster_t    raster,
    input  pattern_pkg::scene_cfg_t scene,
    output pattern_pkg::video_out_t video
);

    logic [9:0]        vis_x;
    logic [9:0]        vis_y;
    logic              in_h;
    logic              in_v;
    logic              in_active;
    logic              in_square;
    pattern_pkg::rgb_t pix_rgb;

    logic              de_q;
    logic              vs_q;
    logic              hs_q;
    pattern_pkg::rgb_t rgb_q;

    //////////////////////////////
    // position compare
    //////////////////////////////

    // coordinates inside the visible window
    assign vis_x = raster.x - 10'(`H_BPORCH);
    assign vis_y = raster.y - 10'(`V_BPORCH);

    assign in_h = (raster.x >= 10'(`H_BPORCH)) &&
                  (raster.x < 10'(`H_BPORCH + `H_ACTIVE));
    assign in_v = (raster.y >= 10'(`V_BPORCH)) &&
                  (raster.y < 10'(`V_BPORCH + `V_ACTIVE));
    assign in_active = in_h && in_v;

    // 11 bit bounds so a square near 1023 does not wrap back to 0
    assign in_square = ({1'b0, vis_x} >= {1'b0, scene.sq_pos.x}) &&
                       ({1'b0, vis_x} < ({1'b0, scene.sq_pos.x} + 11'(`SQUARE_SIZE))) &&
                       ({1'b0, vis_y} >= {1'b0, scene.sq_pos.y}) &&
                       ({1'b0, vis_y} < ({1'b0, scene.sq_pos.y} + 11'(`SQUARE_SIZE)));

    // black outside the active window
    always_comb begin
        if (!in_active)
            pix_rgb = '0;
        else if (in_square)
            pix_rgb = scene.sq_color;
        else
            pix_rgb = scene.bg_color;
    end

    //////////////////////////////
    // output registers
    //////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            de_q  <= 1'b0;
            vs_q  <= 1'b0;
            hs_q  <= 1'b0;
            rgb_q <= '0;
        end else begin
            de_q  <= in_active;
            // vs in the back porch, hs a few clocks later
            vs_q  <= raster.frame_start;
            hs_q  <= (raster.x == 10'(`HS_X));
            rgb_q <= pix_rgb;
        end
    end

    assign video.rgb = rgb_q;
    assign video.de  = de_q;
    assign video.vs  = vs_q;
    assign video.hs  = hs_q;

endmodule

`default_nettype wire

//--- source/i2s_tx.sv
/*
 * i2s serializer
 * bclk = mclk / 4, 32-bit slots, 16 data bits msb first then zeros
 */
`timescale 1ns/1ps
`default_nettype none
`include "pattern_defs.svh"

module i2s_tx (
    input  wire                         audgen_mclk,
    input  wire                         reset_n,
    input  pattern_pkg::stereo_sample_t sample,
    output logic                        audio_bclk,
    output logic                        audio_lrck,
    output logic                        audio_dac
);

    localparam int DIV_W = $clog2(`MCLK_PER_BCLK);
    localparam int PAD_W = `SLOT_BITS - `SAMPLE_BITS;

    logic [DIV_W-1:0]      mclk_div;
    logic                  bclk_fall;
    logic [4:0]            bit_cnt;
    logic                  slot_end;
    logic [`SLOT_BITS-1:0] shreg;
    logic [`SLOT_BITS-1:0] next_slot;
    logic [15:0]           right_hold;

    // bclk is the divider msb
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n)
            mclk_div <= '0;
        else
            mclk_div <= mclk_div + 1'b1;
    end

    assign audio_bclk = mclk_div[DIV_W-1];
    // divider wraps on the clock where bclk drops
    assign bclk_fall  = (mclk_div == DIV_W'(`MCLK_PER_BCLK - 1));
    assign slot_end   = (bit_cnt == 5'(`SLOT_BITS - 1));

    // lrck high now means the next slot is left, latch the pair there
    assign next_slot = audio_lrck ? {sample.left, {PAD_W{1'b0}}}
                                  : {right_hold, {PAD_W{1'b0}}};

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt    <= '0;
            audio_lrck <= 1'b0;
            audio_dac  <= 1'b0;
            shreg      <= '0;
            right_hold <= '0;
        end else if (bclk_fall) begin
            bit_cnt <= bit_cnt + 5'd1;
            if (slot_end) begin
                // left-justified, msb leaves with the lrck edge
                audio_lrck <= ~audio_lrck;
                audio_dac  <= next_slot[`SLOT_BITS-1];
                shreg      <= next_slot << 1;
                if (audio_lrck)
                    right_hold <= sample.right;
            end else begin
                audio_dac <= shreg[`SLOT_BITS-1];
                shreg     <= shreg << 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/pattern_core.sv
/*
 * pattern source top level
 * apb registers, video timing, renderer and i2s serializer on audgen_mclk
 */
`timescale 1ns/1ps
`default_nettype none
`include "pattern_defs.svh"

module pattern_core (
    input  wire                     audgen_mclk,
    input  wire                     reset_n,
    // apb slave
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire  [7:0]              paddr,
    input  wire  [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    // video stream
    output pattern_pkg::video_out_t video,
    // i2s
    output logic                    audio_bclk,
    output logic                    audio_lrck,
    output logic                    audio_dac
);

    pattern_pkg::raster_t        raster;
    pattern_pkg::scene_cfg_t     scene;
    pattern_pkg::stereo_sample_t sample;

    //////////////////////////////
    // control
    //////////////////////////////

    apb_regs u_apb_regs (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .raster      (raster),
        .scene       (scene),
        .sample      (sample)
    );

    //////////////////////////////
    // video
    //////////////////////////////

    video_timing u_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster)
    );

    pattern_render u_pattern_render (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster),
        .scene       (scene),
        .video       (video)
    );

    // audio
    i2s_tx u_i2s_tx (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sample      (sample),
        .audio_bclk  (audio_bclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

endmodule

`default_nettype wire

//--- test/pattern_core_assertions.sv
/*
 * pattern core assertions
 * sync, data enable, apb error and lrck timing rules
 */
`timescale 1ns/1ps
`default_nettype none
`include "pattern_defs.svh"

module pattern_core_assertions (
    input wire                     audgen_mclk,
    input wire                     reset_n,
    input pattern_pkg::video_out_t video,
    input wire                     psel,
    input wire                     penable,
    input wire                     pwrite,
    input wire  [7:0]              paddr,
    input wire                     pslverr,
    input wire                     audio_bclk,
    input wire                     audio_lrck
);

    // vs sits in the blanking area
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !(video.de && video.vs))
        else $error("de and vs high together");

    // single clock hsync
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video.hs |=> !video.hs)
        else $error("hs longer than one cycle");

    // error only in the access phase
    // map is word aligned up to the frame counter, which is read-only
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        pslverr == (psel && penable &&
                    ((paddr[1:0] != 2'b00) || (paddr > `REG_FRAME) ||
                     (pwrite && (paddr == `REG_FRAME)))))
        else $error("pslverr does not match the access phase and offset");

    // word select moves with the bclk falling edge
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $fell(audio_bclk))
        else $error("lrck changed away from a bclk fall");

endmodule

bind pattern_core pattern_core_assertions u_pattern_core_assertions (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .video       (video),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pslverr     (pslverr),
    .audio_bclk  (audio_bclk),
    .audio_lrck  (audio_lrck)
);

`default_nettype wire

//--- test/tb_pattern_core.sv
/*
 * pattern core testbench
 * apb register access, sync timing, pixel colours, motion and i2s
 */
`timescale 1ns/1ps
`default_nettype none
`include "pattern_defs.svh"

module tb_pattern_core;

    localparam int TIMEOUT_CYCLES = 1000000;
    localparam int FRAME_CLKS     = `H_TOTAL * `V_TOTAL;

    logic                    audgen_mclk;
    logic                    reset_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [7:0]              paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    pattern_pkg::video_out_t video;
    logic                    audio_bclk;
    logic                    audio_lrck;
    logic                    audio_dac;

    integer seed = 45;
    int     ticks = 0;
    int     vs_tick = 0;

    pattern_core uut (.*);

    initial begin
        audgen_mclk = 1'b0;
        forever #5 audgen_mclk = ~audgen_mclk;
    end

    // run limit, about 4 frames of tests
    always @(posedge audgen_mclk) begin
        ticks <= ticks + 1;
        if (ticks >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within the cycle limit");
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    ////////////////////////////////
    // apb transfers
    ////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge audgen_mclk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge audgen_mclk);
        #1;
        penable = 1'b1;
        @(negedge audgen_mclk);
        err = pslverr;
        // zero wait states
        check_value("write pready", 32'd1, 32'(pready));
        @(posedge audgen_mclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge audgen_mclk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge audgen_mclk);
        #1;
        penable = 1'b1;
        // read data is combinational in the access phase
        @(negedge audgen_mclk);
        data = prdata;
        err  = pslverr;
        check_value("read pready", 32'd1, 32'(pready));
        @(posedge audgen_mclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [31:0] pos_word(input int x, input int y);
        pattern_pkg::reg_word_u w;
        w       = '0;
        w.pos.x = 10'(x);
        w.pos.y = 10'(y);
        return w;
    endfunction

    task automatic write_check(input string name, input logic [7:0] addr,
                               input logic [31:0] data, input logic [31:0] exp);
        logic        err;
        logic [31:0] rd;
        apb_write(addr, data, err);
        check_value({name, " write err"}, 32'd0, 32'(err));
        apb_read(addr, rd, err);
        check_value(name, exp, rd);
    endtask

    // next vs pulse, sampled mid-cycle
    task automatic wait_vs();
        @(negedge audgen_mclk);
        while (!video.vs)
            @(negedge audgen_mclk);
        vs_tick = ticks;
    endtask

    ////////////////////////////////
    // directed tests
    ////////////////////////////////

    task automatic register_test();
        logic        err;
        logic [31:0] rd;
        logic [31:0] v;
        apb_read(`REG_CTRL, rd, err);
        check_value("reset ctrl", 32'd0, rd);
        apb_read(`REG_BG, rd, err);
        check_value("reset bg", 32'(`BG_RESET), rd);
        apb_read(`REG_SQ_COLOR, rd, err);
        check_value("reset sq colour", 32'(`SQ_RESET), rd);
        apb_read(`REG_SQ_POS, rd, err);
        check_value("reset position", pos_word(`SQUARE_X0, `SQUARE_Y0), rd);
        apb_read(`REG_AUDIO, rd, err);
        check_value("reset audio", 32'd0, rd);
        v = $random(seed);
        write_check("bg readback", `REG_BG, v, {8'd0, v[23:0]});
        v = $random(seed);
        write_check("sq colour readback", `REG_SQ_COLOR, v, {8'd0, v[23:0]});
        v = $random(seed);
        // pad bits of the written word read back as zero
        write_check("position readback", `REG_SQ_POS, v, pos_word(v[25:16], v[9:0]));
        v = $random(seed);
        write_check("audio readback", `REG_AUDIO, v, v);
        apb_read(8'h18, rd, err);
        check_value("unmapped pslverr", 32'd1, 32'(err));
        apb_write(`REG_FRAME, 32'h1234, err);
        check_value("frame write pslverr", 32'd1, 32'(err));
    endtask

    task automatic audio_test();
        logic                        err;
        logic [31:0]                 word;
        int                          t0;
        pattern_pkg::stereo_sample_t s;
        s = $random(seed);
        apb_write(`REG_AUDIO, s, err);
        // align to the start of a left slot
        do begin
            @(negedge audio_bclk);
            #1;
        end while (!audio_lrck);
        do begin
            @(negedge audio_bclk);
            #1;
        end while (audio_lrck);
        for (int half = 0; half < 4; half++) begin
            t0 = ticks;
            word[31] = audio_dac;
            check_value("lrck channel", 32'(half % 2), 32'(audio_lrck));
            for (int i = 30; i >= 0; i--) begin
                @(negedge audio_bclk);
                #1;
                word[i] = audio_dac;
                check_value("lrck channel", 32'(half % 2), 32'(audio_lrck));
            end
            check_value(half % 2 ? "right slot" : "left slot",
                        {half % 2 ? s.right : s.left, 16'h0000}, word);
            @(negedge audio_bclk);
            #1;
            check_value("lrck half length", 32'd128, 32'(ticks - t0));
        end
    endtask

    task automatic motion_test();
        logic        err;
        logic [31:0] f0;
        logic [31:0] p0;
        logic [31:0] rd;
        apb_read(`REG_FRAME, f0, err);
        apb_read(`REG_SQ_POS, p0, err);
        apb_write(`REG_CTRL, 32'd1, err);
        audio_test();
        wait_vs();
        wait_vs();
        apb_read(`REG_FRAME, rd, err);
        check_value("motion frame count", 32'(f0[15:0] + 16'd2), rd);
        apb_read(`REG_SQ_POS, rd, err);
        check_value("motion position", pos_word(p0[25:16] + 2, p0[9:0] + 2), rd);
        apb_write(`REG_CTRL, 32'd0, err);
    endtask

    // one frame from the last vs, de pixels counted by column and line
    task automatic monitor_frame(input string name, input logic [23:0] bg,
                                 input logic [23:0] sq, input int sx, input int sy);
        int          col;
        int          line;
        int          hs_last;
        logic        prev_de;
        logic [23:0] exp;
        col     = 0;
        line    = 0;
        hs_last = -1;
        prev_de = 1'b0;
        @(negedge audgen_mclk);
        while (!video.vs) begin
            if (video.hs) begin
                if (hs_last >= 0)
                    check_value("hs period", 32'd400, 32'(ticks - hs_last));
                hs_last = ticks;
            end
            if (video.de) begin
                exp = (col >= sx && col < sx + `SQUARE_SIZE &&
                       line >= sy && line < sy + `SQUARE_SIZE) ? sq : bg;
                check_value(name, {8'd0, exp}, {8'd0, video.rgb});
                col++;
            end else if (prev_de) begin
                check_value("de width", 32'(`H_ACTIVE), 32'(col));
                col = 0;
                line++;
            end
            prev_de = video.de;
            @(negedge audgen_mclk);
        end
        check_value("de lines", 32'(`V_ACTIVE), 32'(line));
        check_value("vs period", 32'(FRAME_CLKS), 32'(ticks - vs_tick));
        vs_tick = ticks;
    endtask

    task automatic pixel_test();
        logic        err;
        logic [31:0] bg;
        logic [31:0] sq;
        logic [31:0] f0;
        logic [31:0] rd;
        bg = $random(seed);
        sq = $random(seed);
        apb_write(`REG_BG, bg, err);
        apb_write(`REG_SQ_COLOR, sq, err);
        apb_write(`REG_SQ_POS, pos_word(40, 60), err);
        monitor_frame("pixel centre", bg[23:0], sq[23:0], 40, 60);
        // square cut by the right edge
        apb_write(`REG_SQ_POS, pos_word(315, 100), err);
        apb_read(`REG_FRAME, f0, err);
        monitor_frame("pixel right edge", bg[23:0], sq[23:0], 315, 100);
        apb_read(`REG_FRAME, rd, err);
        check_value("static frame count", 32'(f0[15:0] + 16'd1), rd);
        apb_read(`REG_SQ_POS, rd, err);
        check_value("static position", pos_word(315, 100), rd);
    endtask

    initial begin
        reset_n = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge audgen_mclk);
        #1;
        reset_n = 1'b1;
        register_test();
        motion_test();
        pixel_test();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/pattern_pkg.sv
source/apb_regs.sv
source/video_timing.sv
source/pattern_render.sv
source/i2s_tx.sv
source/pattern_core.sv
test/pattern_core_assertions.sv
test/tb_pattern_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pattern_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_pattern_core \
    -f verilog.f \
    -o Vtb_pattern_core

./obj_dir/Vtb_pattern_core | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
